// File: src/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADDU,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI,
        ALU_MFHI,
        ALU_MFLO,
        ALU_MULT
    } alu_op_e;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // SPECIAL function field
    localparam logic [5:0] FN_MFHI = 6'h10;
    localparam logic [5:0] FN_MFLO = 6'h12;
    localparam logic [5:0] FN_MULT = 6'h18;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam addr_t RESET_PC = 32'h0000_0000;

endpackage

// File: src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  reset_i,
    input  logic  stall_i,
    input  logic  branch_taken_i,
    input  addr_t branch_target_i,
    input  word_t rom_data_i,
    output addr_t rom_addr_o,
    output logic  rom_ce_o,
    output addr_t id_pc_o,
    output word_t id_inst_o
);

    logic  ce_q;
    addr_t pc_q;
    addr_t id_pc_q;
    logic  id_valid_q;
    logic  hold_v_q;
    word_t hold_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ce_q       <= 1'b0;
            pc_q       <= RESET_PC;
            id_pc_q    <= RESET_PC;
            id_valid_q <= 1'b0;
            hold_v_q   <= 1'b0;
        end else begin
            ce_q <= 1'b1;
            if (!ce_q) begin
                pc_q <= RESET_PC;
            end else if (!stall_i) begin
                pc_q <= branch_taken_i ? branch_target_i : pc_q + 32'd4;
            end
            if (!stall_i) begin
                id_pc_q    <= pc_q;
                id_valid_q <= ce_q;
            end
            // Stays set through the release cycle so decode still sees the held word
            hold_v_q <= stall_i;
        end
    end

    // Capture decode word on first stalled cycle
    always_ff @(posedge clk) begin
        if (stall_i && !hold_v_q) begin
            hold_q <= id_inst_o;
        end
    end

    assign rom_addr_o = pc_q;
    assign rom_ce_o   = ce_q;
    assign id_pc_o    = id_pc_q;
    assign id_inst_o  = hold_v_q ? hold_q : (id_valid_q ? rom_data_i : '0);

endmodule

// File: src/regfile.sv
`timescale 1ns/1ps

module regfile
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  word_t     wdata_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output word_t     rdata1_o,
    output word_t     rdata2_o
);

    word_t regs_q [32];

    function automatic word_t read_port(reg_addr_t raddr);
        if (raddr == '0) begin
            return '0;
        end else if (we_i && waddr_i == raddr) begin
            return wdata_i;
        end
        return regs_q[raddr];
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = read_port(raddr1_i);
    assign rdata2_o = read_port(raddr2_i);

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import mips_pkg::*;
(
    input  addr_t     pc_i,
    input  word_t     inst_i,
    input  word_t     rdata1_i,
    input  word_t     rdata2_i,
    output reg_addr_t raddr1_o,
    output reg_addr_t raddr2_o,
    input  logic      ex_we_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_we_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i,
    output alu_op_e   aluop_o,
    output word_t     opa_o,
    output word_t     opb_o,
    output reg_addr_t wd_o,
    output logic      we_o,
    output logic      branch_taken_o,
    output addr_t     branch_target_o
);

    logic [5:0]  op;
    logic [5:0]  fn;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [15:0] imm;
    word_t       rs_val;
    word_t       rt_val;
    addr_t       delay_pc;

    assign op       = inst_i[31:26];
    assign rs       = inst_i[25:21];
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign imm      = inst_i[15:0];
    assign fn       = inst_i[5:0];
    assign delay_pc = pc_i + 32'd4;

    assign raddr1_o = rs;
    assign raddr2_o = rt;

    // Newest producer wins, r0 is never forwarded
    function automatic word_t fwd(reg_addr_t addr, word_t rf_val);
        if (addr != '0 && ex_we_i && ex_wd_i == addr) begin
            return ex_wdata_i;
        end else if (addr != '0 && mem_we_i && mem_wd_i == addr) begin
            return mem_wdata_i;
        end
        return rf_val;
    endfunction

    assign rs_val = fwd(rs, rdata1_i);
    assign rt_val = fwd(rt, rdata2_i);

    always_comb begin
        aluop_o         = ALU_NOP;
        opa_o           = rs_val;
        opb_o           = rt_val;
        wd_o            = rd;
        we_o            = 1'b0;
        branch_taken_o  = 1'b0;
        branch_target_o = delay_pc + {{14{imm[15]}}, imm, 2'b00};
        case (op)
            OP_SPECIAL: begin
                we_o = 1'b1;
                case (fn)
                    FN_ADDU: aluop_o = ALU_ADDU;
                    FN_SUBU: aluop_o = ALU_SUBU;
                    FN_AND:  aluop_o = ALU_AND;
                    FN_OR:   aluop_o = ALU_OR;
                    FN_XOR:  aluop_o = ALU_XOR;
                    FN_SLT:  aluop_o = ALU_SLT;
                    FN_MFHI: aluop_o = ALU_MFHI;
                    FN_MFLO: aluop_o = ALU_MFLO;
                    FN_MULT: begin
                        aluop_o = ALU_MULT;
                        we_o    = 1'b0;
                    end
                    default: we_o = 1'b0;
                endcase
            end
            OP_ORI, OP_LUI: begin
                aluop_o = (op == OP_ORI) ? ALU_OR : ALU_LUI;
                opb_o   = {16'h0000, imm};
                wd_o    = rt;
                we_o    = 1'b1;
            end
            OP_BEQ: branch_taken_o = (rs_val == rt_val);
            OP_BNE: branch_taken_o = (rs_val != rt_val);
            OP_J: begin
                branch_taken_o  = 1'b1;
                branch_target_o = {delay_pc[31:28], inst_i[25:0], 2'b00};
            end
            default: ;
        endcase
    end

endmodule

// File: src/mult_unit.sv
`timescale 1ns/1ps

module mult_unit #(
    parameter int MUL_RADIX_BITS = 2
) (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        start_i,
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    output logic        busy_o,
    output logic        done_o,
    output logic [63:0] product_o
);

    localparam int STEPS = 32 / MUL_RADIX_BITS;
    localparam int CNT_W = $clog2(STEPS);

    typedef enum logic {
        MUL_IDLE,
        MUL_RUN
    } mul_state_e;

    mul_state_e       state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             done_q;
    logic             neg_q;
    logic [63:0]      mcand_q;
    logic [31:0]      mplier_q;
    logic [63:0]      acc_q;
    logic [63:0]      partial;

    // Sum of shifted multiplicands for the low multiplier bits
    always_comb begin
        partial = '0;
        for (int i = 0; i < MUL_RADIX_BITS; i++) begin
            if (mplier_q[i]) begin
                partial = partial + (mcand_q << i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= MUL_IDLE;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (state_q == MUL_IDLE && start_i) begin
                state_q <= MUL_RUN;
                cnt_q   <= '0;
            end else if (state_q == MUL_RUN) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == CNT_W'(STEPS - 1)) begin
                    state_q <= MUL_IDLE;
                    done_q  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == MUL_IDLE && start_i) begin
            mcand_q  <= {32'h0, a_i[31] ? -a_i : a_i};
            mplier_q <= b_i[31] ? -b_i : b_i;
            neg_q    <= a_i[31] ^ b_i[31];
            acc_q    <= '0;
        end else if (state_q == MUL_RUN) begin
            acc_q    <= acc_q + partial;
            mcand_q  <= mcand_q << MUL_RADIX_BITS;
            mplier_q <= mplier_q >> MUL_RADIX_BITS;
        end
    end

    assign busy_o    = (state_q == MUL_RUN);
    assign done_o    = done_q;
    assign product_o = neg_q ? -acc_q : acc_q;

endmodule

// File: src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import mips_pkg::*;
#(
    parameter int MUL_RADIX_BITS = 2
) (
    input  logic      clk,
    input  logic      reset_i,
    input  alu_op_e   aluop_i,
    input  word_t     opa_i,
    input  word_t     opb_i,
    input  reg_addr_t wd_i,
    input  logic      we_i,
    input  word_t     hi_i,
    input  word_t     lo_i,
    output logic      we_o,
    output reg_addr_t wd_o,
    output word_t     wdata_o,
    output logic      whilo_o,
    output word_t     hi_o,
    output word_t     lo_o,
    output logic      stall_o
);

    alu_op_e     aluop_q;
    logic        we_q;
    word_t       opa_q;
    word_t       opb_q;
    reg_addr_t   wd_q;
    logic        is_mult;
    logic        mul_start;
    logic        mul_busy;
    logic        mul_done;
    logic [63:0] mul_product;

    // ID/EX register, frozen while the multiplier runs
    always_ff @(posedge clk) begin
        if (reset_i) begin
            aluop_q <= ALU_NOP;
            we_q    <= 1'b0;
        end else if (!stall_o) begin
            aluop_q <= aluop_i;
            we_q    <= we_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            opa_q <= opa_i;
            opb_q <= opb_i;
            wd_q  <= wd_i;
        end
    end

    always_comb begin
        case (aluop_q)
            ALU_ADDU: wdata_o = opa_q + opb_q;
            ALU_SUBU: wdata_o = opa_q - opb_q;
            ALU_AND:  wdata_o = opa_q & opb_q;
            ALU_OR:   wdata_o = opa_q | opb_q;
            ALU_XOR:  wdata_o = opa_q ^ opb_q;
            ALU_SLT:  wdata_o = {31'b0, $signed(opa_q) < $signed(opb_q)};
            ALU_LUI:  wdata_o = {opb_q[15:0], 16'h0000};
            ALU_MFHI: wdata_o = hi_i;
            ALU_MFLO: wdata_o = lo_i;
            default:  wdata_o = '0;
        endcase
    end

    // MULT holds execute from entry until the done pulse
    assign is_mult   = (aluop_q == ALU_MULT);
    assign mul_start = is_mult && !mul_busy && !mul_done;
    assign stall_o   = is_mult && !mul_done;
    assign whilo_o   = is_mult && mul_done;

    mult_unit #(
        .MUL_RADIX_BITS(MUL_RADIX_BITS)
    ) i_mult_unit (
        .clk      (clk),
        .reset_i  (reset_i),
        .start_i  (mul_start),
        .a_i      (opa_q),
        .b_i      (opb_q),
        .busy_o   (mul_busy),
        .done_o   (mul_done),
        .product_o(mul_product)
    );

    assign we_o = we_q;
    assign wd_o = wd_q;
    assign hi_o = mul_product[63:32];
    assign lo_o = mul_product[31:0];

endmodule

// File: src/commit_stage.sv
`timescale 1ns/1ps

module commit_stage
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      ex_we_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,
    input  logic      ex_whilo_i,
    input  word_t     ex_hi_i,
    input  word_t     ex_lo_i,
    output logic      mem_we_o,
    output reg_addr_t mem_wd_o,
    output word_t     mem_wdata_o,
    output logic      wb_we_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o,
    output word_t     hilo_hi_o,
    output word_t     hilo_lo_o,
    output word_t     hi_o,
    output word_t     lo_o
);

    logic      mem_whilo_q;
    word_t     mem_hi_q;
    word_t     mem_lo_q;
    logic      wb_whilo_q;
    word_t     wb_hi_q;
    word_t     wb_lo_q;
    word_t     hi_q;
    word_t     lo_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_we_o    <= 1'b0;
            mem_whilo_q <= 1'b0;
            wb_we_o     <= 1'b0;
            wb_whilo_q  <= 1'b0;
            hi_q        <= '0;
            lo_q        <= '0;
        end else begin
            mem_we_o    <= ex_we_i;
            mem_whilo_q <= ex_whilo_i;
            wb_we_o     <= mem_we_o;
            wb_whilo_q  <= mem_whilo_q;
            if (wb_whilo_q) begin
                hi_q <= wb_hi_q;
                lo_q <= wb_lo_q;
            end
        end
    end

    // Memory stage has no work of its own, data moves straight on
    always_ff @(posedge clk) begin
        mem_wd_o    <= ex_wd_i;
        mem_wdata_o <= ex_wdata_i;
        mem_hi_q    <= ex_hi_i;
        mem_lo_q    <= ex_lo_i;
        wb_addr_o   <= mem_wd_o;
        wb_data_o   <= mem_wdata_o;
        wb_hi_q     <= mem_hi_q;
        wb_lo_q     <= mem_lo_q;
    end

    assign hilo_hi_o = mem_whilo_q ? mem_hi_q : (wb_whilo_q ? wb_hi_q : hi_q);
    assign hilo_lo_o = mem_whilo_q ? mem_lo_q : (wb_whilo_q ? wb_lo_q : lo_q);
    assign hi_o      = hi_q;
    assign lo_o      = lo_q;

endmodule

// File: src/openmips.sv
`timescale 1ns/1ps

module openmips
    import mips_pkg::*;
#(
    parameter int MUL_RADIX_BITS = 2
) (
    input  logic      clk,
    input  logic      reset_i,
    input  word_t     rom_data_i,
    output addr_t     rom_addr_o,
    output logic      rom_ce_o,
    output logic      wb_we_o,
    output reg_addr_t wb_addr_o,
    output word_t     wb_data_o,
    output word_t     hi_o,
    output word_t     lo_o
);

    logic      stall;
    logic      branch_taken;
    addr_t     branch_target;
    addr_t     id_pc;
    word_t     id_inst;

    // Decode to regfile
    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t     rdata1;
    word_t     rdata2;

    // Decode to execute
    alu_op_e   id_aluop;
    word_t     id_opa;
    word_t     id_opb;
    reg_addr_t id_wd;
    logic      id_we;

    // Execute results
    logic      ex_we;
    reg_addr_t ex_wd;
    word_t     ex_wdata;
    logic      ex_whilo;
    word_t     ex_hi;
    word_t     ex_lo;

    logic      mem_we;
    reg_addr_t mem_wd;
    word_t     mem_wdata;
    word_t     hilo_hi;
    word_t     hilo_lo;

    fetch_stage i_fetch_stage (
        .clk            (clk),
        .reset_i        (reset_i),
        .stall_i        (stall),
        .branch_taken_i (branch_taken),
        .branch_target_i(branch_target),
        .rom_data_i     (rom_data_i),
        .rom_addr_o     (rom_addr_o),
        .rom_ce_o       (rom_ce_o),
        .id_pc_o        (id_pc),
        .id_inst_o      (id_inst)
    );

    regfile i_regfile (
        .clk     (clk),
        .reset_i (reset_i),
        .we_i    (wb_we_o),
        .waddr_i (wb_addr_o),
        .wdata_i (wb_data_o),
        .raddr1_i(raddr1),
        .raddr2_i(raddr2),
        .rdata1_o(rdata1),
        .rdata2_o(rdata2)
    );

    decode_stage i_decode_stage (
        .pc_i           (id_pc),
        .inst_i         (id_inst),
        .rdata1_i       (rdata1),
        .rdata2_i       (rdata2),
        .raddr1_o       (raddr1),
        .raddr2_o       (raddr2),
        .ex_we_i        (ex_we),
        .ex_wd_i        (ex_wd),
        .ex_wdata_i     (ex_wdata),
        .mem_we_i       (mem_we),
        .mem_wd_i       (mem_wd),
        .mem_wdata_i    (mem_wdata),
        .aluop_o        (id_aluop),
        .opa_o          (id_opa),
        .opb_o          (id_opb),
        .wd_o           (id_wd),
        .we_o           (id_we),
        .branch_taken_o (branch_taken),
        .branch_target_o(branch_target)
    );

    execute_stage #(
        .MUL_RADIX_BITS(MUL_RADIX_BITS)
    ) i_execute_stage (
        .clk    (clk),
        .reset_i(reset_i),
        .aluop_i(id_aluop),
        .opa_i  (id_opa),
        .opb_i  (id_opb),
        .wd_i   (id_wd),
        .we_i   (id_we),
        .hi_i   (hilo_hi),
        .lo_i   (hilo_lo),
        .we_o   (ex_we),
        .wd_o   (ex_wd),
        .wdata_o(ex_wdata),
        .whilo_o(ex_whilo),
        .hi_o   (ex_hi),
        .lo_o   (ex_lo),
        .stall_o(stall)
    );

    commit_stage i_commit_stage (
        .clk        (clk),
        .reset_i    (reset_i),
        .ex_we_i    (ex_we),
        .ex_wd_i    (ex_wd),
        .ex_wdata_i (ex_wdata),
        .ex_whilo_i (ex_whilo),
        .ex_hi_i    (ex_hi),
        .ex_lo_i    (ex_lo),
        .mem_we_o   (mem_we),
        .mem_wd_o   (mem_wd),
        .mem_wdata_o(mem_wdata),
        .wb_we_o    (wb_we_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o),
        .hilo_hi_o  (hilo_hi),
        .hilo_lo_o  (hilo_lo),
        .hi_o       (hi_o),
        .lo_o       (lo_o)
    );

endmodule

// File: tb/openmips_tb.sv
`timescale 1ns/1ps

module openmips_tb
    import mips_pkg::*;
();

    localparam int MUL_RADIX_BITS = 2;
    localparam int ROM_WORDS      = 256;
    // Radix 1 is the slowest multiplier: 32 steps plus the release cycle
    localparam int WORST_STALL    = 33;

    logic      clk;
    logic      reset_i;
    word_t     rom_data_i;
    addr_t     rom_addr_o;
    logic      rom_ce_o;
    logic      wb_we_o;
    reg_addr_t wb_addr_o;
    word_t     wb_data_o;
    word_t     hi_o;
    word_t     lo_o;

    word_t     rom [ROM_WORDS];
    int        n_inst;
    integer    seed;

    reg_addr_t exp_addr_q [$];
    word_t     exp_data_q [$];
    word_t     exp_hi;
    word_t     exp_lo;
    int        exp_count;
    int        exec_count;
    int        wr_idx;
    int        cycle_cnt;
    int        cycle_limit;
    int        run_cycles;

    openmips #(
        .MUL_RADIX_BITS(MUL_RADIX_BITS)
    ) i_openmips (
        .clk       (clk),
        .reset_i   (reset_i),
        .rom_data_i(rom_data_i),
        .rom_addr_o(rom_addr_o),
        .rom_ce_o  (rom_ce_o),
        .wb_we_o   (wb_we_o),
        .wb_addr_o (wb_addr_o),
        .wb_data_o (wb_data_o),
        .hi_o      (hi_o),
        .lo_o      (lo_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Synchronous ROM, data one cycle after the address
    always @(posedge clk) begin
        if (rom_ce_o && rom_addr_o < ROM_WORDS * 4) begin
            rom_data_i <= rom[rom_addr_o[9:2]];
        end else begin
            rom_data_i <= '0;
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("Mismatch %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    function automatic word_t r_type(logic [5:0] fn, reg_addr_t rs, reg_addr_t rt,
                                     reg_addr_t rd);
        return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t i_type(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_type(addr_t target);
        return {OP_J, target[27:2]};
    endfunction

    task automatic put_inst(input word_t w);
        rom[n_inst] = w;
        n_inst++;
    endtask

    task automatic load_word(input reg_addr_t r, input word_t v);
        put_inst(i_type(OP_LUI, 0, r, v[31:16]));
        put_inst(i_type(OP_ORI, r, r, v[15:0]));
    endtask

    task automatic build_program();
        word_t a;
        word_t b;
        int    at;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rom[i] = '0;
        end
        n_inst = 0;
        // ALU chain, each op reads from EX, MEM or the write-through port
        put_inst(i_type(OP_ORI, 0, 1, 16'h1234));
        put_inst(i_type(OP_LUI, 0, 2, 16'h8000));
        put_inst(i_type(OP_ORI, 2, 2, 16'h0005));
        put_inst(r_type(FN_ADDU, 1, 2, 3));
        put_inst(r_type(FN_SUBU, 1, 3, 4));
        put_inst(r_type(FN_AND, 3, 4, 5));
        put_inst(r_type(FN_OR, 4, 5, 6));
        put_inst(r_type(FN_XOR, 5, 6, 7));
        put_inst(r_type(FN_SLT, 2, 1, 8));
        put_inst(r_type(FN_SLT, 1, 2, 9));
        put_inst(i_type(OP_LUI, 0, 10, 16'hffff));
        put_inst(i_type(OP_ORI, 10, 10, 16'hfff0));
        put_inst(r_type(FN_SLT, 10, 9, 11));
        put_inst(r_type(FN_ADDU, 10, 8, 12));
        // Taken BEQ skips one word after the delay slot
        put_inst(i_type(OP_BEQ, 8, 11, 16'd2));
        put_inst(i_type(OP_ORI, 0, 13, 16'h0011));
        put_inst(i_type(OP_ORI, 0, 14, 16'h0bad));
        put_inst(i_type(OP_ORI, 0, 15, 16'h0022));
        put_inst(i_type(OP_BNE, 8, 11, 16'd2));
        put_inst(i_type(OP_ORI, 0, 16, 16'h0033));
        put_inst(i_type(OP_ORI, 0, 17, 16'h0044));
        put_inst(i_type(OP_BEQ, 1, 2, 16'd2));
        put_inst(i_type(OP_ORI, 0, 18, 16'h0055));
        put_inst(i_type(OP_ORI, 0, 19, 16'h0066));
        // Branch operand comes straight from the execute stage
        put_inst(i_type(OP_ORI, 0, 21, 16'h0005));
        put_inst(i_type(OP_BNE, 21, 1, 16'd2));
        put_inst(r_type(FN_ADDU, 21, 21, 18));
        put_inst(i_type(OP_ORI, 0, 19, 16'h0bad));
        put_inst(i_type(OP_ORI, 0, 20, 16'h0077));
        at = n_inst;
        put_inst(j_type((at + 3) * 4));
        put_inst(r_type(FN_SUBU, 1, 21, 20));
        put_inst(i_type(OP_ORI, 0, 14, 16'h0bad));
        put_inst(i_type(OP_ORI, 13, 13, 16'h0100));
        // Random signed products, with the MULT fed by forwarded operands
        for (int k = 0; k < 4; k++) begin
            a = $random(seed);
            b = $random(seed);
            load_word(22, a);
            load_word(23, b);
            put_inst(r_type(FN_MULT, 22, 23, 0));
            case (k)
                0: begin
                    put_inst(r_type(FN_MFHI, 0, 0, 24));
                    put_inst(r_type(FN_MFLO, 0, 0, 25));
                end
                1: begin
                    put_inst(i_type(OP_BNE, 22, 23, 16'd2));
                    put_inst(r_type(FN_ADDU, 22, 23, 26));
                    put_inst(i_type(OP_ORI, 0, 27, 16'hdead));
                    put_inst(r_type(FN_MFHI, 0, 0, 24));
                    put_inst(r_type(FN_MFLO, 0, 0, 25));
                end
                2: begin
                    put_inst(r_type(FN_ADDU, 24, 25, 26));
                    put_inst(r_type(FN_MULT, 23, 26, 0));
                    put_inst(r_type(FN_MFLO, 0, 0, 25));
                    put_inst(r_type(FN_MFHI, 0, 0, 24));
                end
                default: begin
                    at = n_inst;
                    put_inst(j_type((at + 3) * 4));
                    put_inst(r_type(FN_SUBU, 22, 23, 28));
                    put_inst(i_type(OP_ORI, 0, 29, 16'hbeef));
                    put_inst(r_type(FN_MFLO, 0, 0, 25));
                    put_inst(r_type(FN_MFHI, 0, 0, 24));
                end
            endcase
        end
        put_inst(i_type(OP_ORI, 0, 30, 16'h0077));
    endtask

    // Sequential MIPS32 semantics with one delay slot per branch
    function automatic void isa_model();
        word_t             regs [32];
        word_t             hi;
        word_t             lo;
        addr_t             pc;
        addr_t             npc;
        addr_t             nnpc;
        addr_t             dpc;
        word_t             inst;
        word_t             a;
        word_t             b;
        word_t             res;
        logic              wr;
        reg_addr_t         wa;
        logic signed [63:0] prod;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        hi         = '0;
        lo         = '0;
        pc         = RESET_PC;
        npc        = RESET_PC + 32'd4;
        exec_count = 0;
        while (pc < n_inst * 4 && exec_count < 4096) begin
            inst = rom[pc[9:2]];
            a    = regs[inst[25:21]];
            b    = regs[inst[20:16]];
            dpc  = pc + 32'd4;
            nnpc = npc + 32'd4;
            wr   = 1'b0;
            wa   = inst[15:11];
            res  = '0;
            case (inst[31:26])
                OP_SPECIAL: begin
                    wr = 1'b1;
                    case (inst[5:0])
                        FN_ADDU: res = a + b;
                        FN_SUBU: res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_MFHI: res = hi;
                        FN_MFLO: res = lo;
                        FN_MULT: begin
                            wr   = 1'b0;
                            prod = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
                            hi   = prod[63:32];
                            lo   = prod[31:0];
                        end
                        default: wr = 1'b0;
                    endcase
                end
                OP_ORI: begin
                    wr  = 1'b1;
                    wa  = inst[20:16];
                    res = a | {16'h0000, inst[15:0]};
                end
                OP_LUI: begin
                    wr  = 1'b1;
                    wa  = inst[20:16];
                    res = {inst[15:0], 16'h0000};
                end
                OP_BEQ: begin
                    if (a == b) begin
                        nnpc = dpc + {{14{inst[15]}}, inst[15:0], 2'b00};
                    end
                end
                OP_BNE: begin
                    if (a != b) begin
                        nnpc = dpc + {{14{inst[15]}}, inst[15:0], 2'b00};
                    end
                end
                OP_J: nnpc = {dpc[31:28], inst[25:0], 2'b00};
                default: ;
            endcase
            if (wr) begin
                if (wa != '0) begin
                    regs[wa] = res;
                end
                exp_addr_q.push_back(wa);
                exp_data_q.push_back(res);
            end
            pc  = npc;
            npc = nnpc;
            exec_count++;
        end
        exp_hi = hi;
        exp_lo = lo;
    endfunction

    // Fetch is off through reset and the cycle after it, then stays on
    always @(negedge clk) begin
        if (reset_i || run_cycles == 0) begin
            check_value("rom_ce_o", rom_ce_o, 1'b0);
            check_value("rom_addr_o", rom_addr_o, RESET_PC);
            check_value("wb_we_o", wb_we_o, 1'b0);
        end else begin
            check_value("rom_ce_o", rom_ce_o, 1'b1);
        end
        if (!reset_i) begin
            run_cycles++;
        end
    end

    // In-order writeback compare
    always @(negedge clk) begin
        if (!reset_i && wb_we_o) begin
            if (wr_idx >= exp_count) begin
                fail_run("Register write seen after the last expected write");
            end else begin
                check_value("wb_addr_o", wb_addr_o, exp_addr_q[wr_idx]);
                check_value("wb_data_o", wb_data_o, exp_data_q[wr_idx]);
                wr_idx++;
            end
        end
    end

    always @(negedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            fail_run($sformatf("Timeout after %0d cycles with %0d of %0d writes seen",
                               cycle_limit, wr_idx, exp_count));
        end
    end

    initial begin
        reset_i    = 1'b1;
        rom_data_i = '0;
        wr_idx     = 0;
        cycle_cnt  = 0;
        run_cycles = 0;
        seed       = 32'h64ac_6063;
        build_program();
        isa_model();
        exp_count   = exp_addr_q.size();
        cycle_limit = exec_count * WORST_STALL + 100;
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;
        wait (wr_idx == exp_count);
        // Idle cycles catch a late or repeated write
        repeat (10) @(negedge clk);
        check_value("hi_o", hi_o, exp_hi);
        check_value("lo_o", lo_o, exp_lo);
        $display("All tests passed");
        $finish;
    end

endmodule

// File: filelist.f
src/mips_pkg.sv
src/fetch_stage.sv
src/regfile.sv
src/decode_stage.sv
src/mult_unit.sv
src/execute_stage.sv
src/commit_stage.sv
src/openmips.sv
tb/openmips_tb.sv

// File: Bender.yml
package:
  name: openmips

sources:
  - src/mips_pkg.sv
  - src/fetch_stage.sv
  - src/regfile.sv
  - src/decode_stage.sv
  - src/mult_unit.sv
  - src/execute_stage.sv
  - src/commit_stage.sv
  - src/openmips.sv
  - target: test
    files:
      - tb/openmips_tb.sv
